/* bench/ray_tri_unit_props.sv */
module ray_tri_unit_props import isect_pkg::*; #(
  parameter int TRI_COUNT   = 8,
  parameter int RAY_SLOTS   = 2,
  parameter int RES_CREDITS = 2
) (
  input logic    clk,
  input logic    rst,
  input logic    ray_valid,
  input logic    ray_credit,
  input logic    tri_rd_en,
  input tri_id_t tri_rd_addr,
  input logic    res_valid,
  input logic    res_credit
);
  timeunit 1ns;
  timeprecision 1ps;

  int rays_held;    // accepted rays not yet credited back
  int res_held;     // results not yet credited back

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rays_held <= 0;
      res_held  <= 0;
    end else begin
      rays_held <= rays_held + int'(ray_valid) - int'(ray_credit);
      res_held  <= res_held + int'(res_valid) - int'(res_credit);
    end
  end

  addr_in_range: assert property (@(posedge clk) disable iff (rst)
    tri_rd_en |-> tri_rd_addr < TRI_COUNT)
    else $error("tri_rd_addr %0d read beyond the triangle table", tri_rd_addr);

  quiet_in_reset: assert property (@(posedge clk) rst |-> !(ray_credit || tri_rd_en || res_valid))
    else $error("output strobe high during reset");

  result_bound: assert property (@(posedge clk) disable iff (rst) res_held <= RES_CREDITS)
    else $error("%0d results outstanding against %0d credits", res_held, RES_CREDITS);

  credit_bound: assert property (@(posedge clk) disable iff (rst) ray_credit |-> rays_held > 0)
    else $error("ray_credit returned with no ray held");

endmodule

bind ray_tri_unit ray_tri_unit_props #(
  .TRI_COUNT(TRI_COUNT), .RAY_SLOTS(RAY_SLOTS), .RES_CREDITS(RES_CREDITS)
) u_props (
  .clk(clk), .rst(rst), .ray_valid(ray_valid), .ray_credit(ray_credit), .tri_rd_en(tri_rd_en),
  .tri_rd_addr(tri_rd_addr), .res_valid(res_valid), .res_credit(res_credit)
);

/* bench/ray_tri_unit_tb.sv */
module ray_tri_unit_tb import isect_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TRI_COUNT   = 8;
  localparam int RAY_SLOTS   = 2;
  localparam int RES_CREDITS = 2;
  localparam int MAX_CYCLES  = 300 * (TRI_COUNT + 12) * 3;

  typedef struct packed {
    tag_t    tag;
    logic    hit;
    tri_id_t id;
    prod_t   t_num;
    prod_t   det;
  } result_t;

  logic    clk, rst, ray_valid, ray_credit, tri_rd_en, res_valid, res_hit, res_credit;
  vec_t    ray_orig, ray_dir, tri_v0, tri_v1, tri_v2;
  tag_t    ray_tag, res_tag;
  tri_id_t tri_rd_addr, res_tri_id;
  prod_t   res_t_num, res_det;

  vec_t    mem_v0 [TRI_COUNT];    // triangle memory model
  vec_t    mem_v1 [TRI_COUNT];
  vec_t    mem_v2 [TRI_COUNT];
  result_t exp_q [$];             // expected results in ray order
  int      seed = 32'h196e;
  int      crd_seed;              // consumer delays draw from their own stream
  int      cycle = 0;
  int      src_credits, owed, credit_wait, sent, received, mismatches, other_errors;
  logic    bp_mode;

  ray_tri_unit #(.TRI_COUNT(TRI_COUNT), .RAY_SLOTS(RAY_SLOTS), .RES_CREDITS(RES_CREDITS)) dut (.*);

  function automatic int rnd(int lo, int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic vec_t mk_vec(int x, int y, int z);
    return {coord_t'(z), coord_t'(y), coord_t'(x)};
  endfunction

  function automatic longint comp(vec_t v, int i);
    return longint'(coord_t'(v[COORD_W*i +: COORD_W]));
  endfunction

  function automatic longint abs_val(longint x);
    return (x < 0) ? -x : x;
  endfunction

  // exact hit rule, t and det returned for the closest-hit choice
  function automatic bit tri_hit(vec_t o, vec_t d, vec_t a, vec_t b, vec_t c,
                                 output longint t, output longint dt);
    longint e1 [3], e2 [3], tv [3], dv [3], p [3], q [3];
    longint u, v, s;
    int     j, k;
    for (int i = 0; i < 3; i++) begin
      e1[i] = comp(b, i) - comp(a, i);
      e2[i] = comp(c, i) - comp(a, i);
      tv[i] = comp(o, i) - comp(a, i);
      dv[i] = comp(d, i);
    end
    for (int i = 0; i < 3; i++) begin
      j = (i + 1) % 3;
      k = (i + 2) % 3;
      p[i] = dv[j] * e2[k] - dv[k] * e2[j];    // dir x e2
      q[i] = tv[j] * e1[k] - tv[k] * e1[j];    // tvec x e1
    end
    dt = 0;
    u  = 0;
    v  = 0;
    t  = 0;
    for (int i = 0; i < 3; i++) begin
      dt += e1[i] * p[i];
      u  += tv[i] * p[i];
      v  += dv[i] * q[i];
      t  += e2[i] * q[i];
    end
    s = (dt < 0) ? -1 : 1;
    return dt != 0 && s * u >= 0 && s * v >= 0 && s * (u + v) <= s * dt && s * t > 0;
  endfunction

  function automatic result_t model_ray(vec_t o, vec_t d, tag_t tag);
    result_t      r;
    longint       t, dt, bt, bd;
    logic [127:0] lhs, rhs;
    r     = '0;
    r.tag = tag;
    bt    = 0;
    bd    = 0;
    for (int k = 0; k < TRI_COUNT; k++) begin
      if (tri_hit(o, d, mem_v0[k], mem_v1[k], mem_v2[k], t, dt)) begin
        lhs = 128'(abs_val(t)) * 128'(abs_val(bd));
        rhs = 128'(abs_val(bt)) * 128'(abs_val(dt));
        if (!r.hit || lhs < rhs) begin    // equal distance keeps the earlier index
          r.hit   = 1'b1;
          r.id    = tri_id_t'(k);
          r.t_num = prod_t'(t);
          r.det   = prod_t'(dt);
          bt      = t;
          bd      = dt;
        end
      end
    end
    return r;
  endfunction

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic note_error(string msg);
    $display("ERROR: %s", msg);
    other_errors++;
  endtask

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other, %0d rays sent, %0d results seen",
             mismatches, other_errors, sent, received);
    if (mismatches == 0 && other_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  endtask

  // kind 0 random, 1 stacked planes with a tie, 2 misses and degenerate triangles
  task automatic load_scene(int kind);
    int x, y, z;
    for (int k = 0; k < TRI_COUNT; k++) begin
      x = rnd(-900, 900);
      y = rnd(-900, 900);
      z = rnd(-200, 600);
      if (kind == 0) begin
        mem_v0[k] = mk_vec(x, y, z);
        mem_v1[k] = mk_vec(x + rnd(-700, 700), y + rnd(-700, 700), z + rnd(-700, 700));
        mem_v2[k] = mk_vec(x + rnd(-700, 700), y + rnd(-700, 700), z + rnd(-700, 700));
      end else if (kind == 1) begin
        z = (k == 2 || k == TRI_COUNT - 1) ? 80 : 600 - 50 * k;    // 2 and last tie nearest
        mem_v0[k] = mk_vec(-1500, -1200, z);
        mem_v1[k] = (k % 2) ? mk_vec(0, 1800, z) : mk_vec(1500, -1200, z);    // odd ones flipped
        mem_v2[k] = (k % 2) ? mk_vec(1500, -1200, z) : mk_vec(0, 1800, z);
      end else begin
        case (k % 4)
          0: begin    // collinear
            mem_v0[k] = mk_vec(0, 0, 300);
            mem_v1[k] = mk_vec(100, 100, 300);
            mem_v2[k] = mk_vec(200, 200, 300);
          end
          1: begin    // plane holds the ray direction
            mem_v0[k] = mk_vec(500, -100, 0);
            mem_v1[k] = mk_vec(500, 100, 0);
            mem_v2[k] = mk_vec(500, 0, 400);
          end
          2: begin    // behind the origin
            mem_v0[k] = mk_vec(-1500, -1200, -300);
            mem_v1[k] = mk_vec(1500, -1200, -300);
            mem_v2[k] = mk_vec(0, 1800, -300);
          end
          default: begin    // plane is crossed outside the edges
            mem_v0[k] = mk_vec(1500, 1500, 300);
            mem_v1[k] = mk_vec(1600, 1500, 300);
            mem_v2[k] = mk_vec(1500, 1600, 300);
          end
        endcase
      end
    end
  endtask

  task automatic send_rays(int count, int kind);
    vec_t o, d;
    int   gap;
    for (int n = 0; n < count; n++) begin
      while (src_credits == 0) begin
        @(posedge clk);
        #5;
      end
      if (kind == 0) begin
        o = mk_vec(rnd(-300, 300), rnd(-300, 300), rnd(-1000, -600));
        d = mk_vec(rnd(-60, 60), rnd(-60, 60), (rnd(0, 7) == 0) ? rnd(-200, -20) : rnd(20, 200));
      end else if (kind == 1) begin
        o = mk_vec(rnd(-100, 100), rnd(-100, 100), -500);
        d = mk_vec(rnd(-20, 20), rnd(-20, 20), rnd(50, 200));
      end else begin
        o = mk_vec(rnd(-50, 50), rnd(-50, 50), 0);
        d = mk_vec(0, rnd(-3, 3), rnd(50, 300));
      end
      ray_orig  = o;
      ray_dir   = d;
      ray_tag   = tag_t'(sent);
      ray_valid = 1'b1;
      exp_q.push_back(model_ray(o, d, tag_t'(sent)));
      src_credits--;
      sent++;
      @(posedge clk);
      #5;
      ray_valid = 1'b0;
      gap = rnd(0, 3);
      repeat (gap) begin
        @(posedge clk);
        #5;
      end
    end
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk);
      #5;
    end while (exp_q.size() != 0 || owed != 0);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // memory answers one cycle after the read
  initial begin
    logic    en;
    tri_id_t addr;
    forever begin
      @(negedge clk);
      en   = tri_rd_en;
      addr = tri_rd_addr;
      @(posedge clk);
      #5;
      if (en && addr < TRI_COUNT) begin
        tri_v0 = mem_v0[addr];
        tri_v1 = mem_v1[addr];
        tri_v2 = mem_v2[addr];
      end
    end
  end

  // consumer hands result credits back after a random delay
  initial begin
    forever begin
      @(posedge clk);
      #5;
      res_credit = 1'b0;
      if (owed > 0 && !(bp_mode && cycle % 300 < 200)) begin    // long stalls in bp_mode
        if (credit_wait > 0) begin
          credit_wait--;
        end else begin
          res_credit  = 1'b1;
          owed--;
          credit_wait = int'($unsigned($random(crd_seed)) % 7);
        end
      end
    end
  end

  always @(negedge clk) begin : monitor
    result_t e;
    if (ray_credit) begin
      if (src_credits >= RAY_SLOTS)
        note_error("ray_credit pulse with no ray held by the unit");
      else
        src_credits++;
    end
    if (res_valid) begin
      received++;
      owed++;
      if (owed > RES_CREDITS)
        note_error("more results delivered than result credits allow");
      if (exp_q.size() == 0) begin
        note_error("result arrived with no ray outstanding");
      end else begin
        e = exp_q.pop_front();
        check("res_tag", res_tag, e.tag);
        check("res_hit", res_hit, e.hit);
        check("res_tri_id", res_tri_id, e.id);
        check("res_t_num", res_t_num, e.t_num);
        check("res_det", res_det, e.det);
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      note_error($sformatf("timeout after %0d cycles, %0d results never arrived",
                           cycle, exp_q.size()));
      finish_run();
    end
  end

  initial begin
    rst         = 1'b1;
    ray_valid   = 1'b0;
    ray_orig    = '0;
    ray_dir     = '0;
    ray_tag     = '0;
    tri_v0      = '0;
    tri_v1      = '0;
    tri_v2      = '0;
    res_credit  = 1'b0;
    bp_mode     = 1'b0;
    src_credits = RAY_SLOTS;
    owed        = 0;
    credit_wait = 0;
    sent        = 0;
    received    = 0;
    mismatches  = 0;
    other_errors = 0;
    crd_seed    = ~seed;
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;
    repeat (20) begin    // idle unit stays quiet
      @(negedge clk);
      check("ray_credit", ray_credit, 0);
      check("tri_rd_en", tri_rd_en, 0);
      check("res_valid", res_valid, 0);
    end
    @(posedge clk);
    #5;
    load_scene(0);
    send_rays(150, 0);
    wait_idle();
    load_scene(1);
    send_rays(50, 1);
    wait_idle();
    load_scene(2);
    send_rays(50, 2);
    wait_idle();
    bp_mode = 1'b1;
    load_scene(0);
    send_rays(50, 0);
    wait_idle();
    bp_mode = 1'b0;
    check("results", received, sent);
    check("ray_credits", src_credits, RAY_SLOTS);
    finish_run();
  end

endmodule

/* ray_tri_unit.f */
verilog/isect_pkg.sv
verilog/vec_cross.sv
verilog/vec_dot.sv
verilog/isect_pipe.sv
verilog/tri_fetch.sv
verilog/hit_select.sv
verilog/ray_tri_unit.sv
bench/ray_tri_unit_props.sv
bench/ray_tri_unit_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f ray_tri_unit.f \
  --top-module ray_tri_unit_tb -o ray_tri_unit_sim &&
./obj_dir/ray_tri_unit_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "simulation run: pass" ||
{ echo "simulation run: fail"; exit 1; }

/* verilog/hit_select.sv */
module hit_select import isect_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    hit_valid,
  input  logic    hit,
  input  prod_t   t_num,
  input  prod_t   det,
  input  tri_id_t tri_id,
  input  tag_t    tag,
  input  logic    last,
  output logic    res_valid,
  output tag_t    res_tag,
  output logic    res_hit,
  output tri_id_t res_tri_id,
  output prod_t   res_t_num,
  output prod_t   res_det
);

  logic               fresh;       // next triangle starts a new ray
  logic               best_hit;
  tri_id_t            best_id;
  prod_t              best_t, best_det;
  logic [PROD_W-1:0]  cand_t_mag, cand_d_mag, best_t_mag, best_d_mag;
  logic [2*PROD_W-1:0] lhs, rhs;
  logic               base_hit, closer, take, nxt_hit;
  tri_id_t            nxt_id;
  prod_t              nxt_t, nxt_det;

  function automatic logic [PROD_W-1:0] mag(prod_t x);
    return x[PROD_W-1] ? PROD_W'(-x) : PROD_W'(x);
  endfunction

  // for a hit s*t_num > 0, so |t_num| is the sign-normalized numerator
  assign cand_t_mag = mag(t_num);
  assign cand_d_mag = mag(det);
  assign best_t_mag = mag(best_t);
  assign best_d_mag = mag(best_det);

  // t_c/det_c < t_b/det_b without a divide
  assign lhs    = cand_t_mag * best_d_mag;
  assign rhs    = best_t_mag * cand_d_mag;
  assign closer = lhs < rhs;    // strict, so a tie keeps the lower index

  assign base_hit = best_hit && !fresh;
  assign take     = hit && (!base_hit || closer);
  assign nxt_hit  = base_hit || take;
  assign nxt_id   = take ? tri_id : best_id;
  assign nxt_t    = take ? t_num : best_t;
  assign nxt_det  = take ? det : best_det;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fresh     <= 1'b1;
      best_hit  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= hit_valid && last;
      if (hit_valid) begin
        fresh    <= last;
        best_hit <= nxt_hit;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit_valid) begin
      best_id  <= nxt_id;
      best_t   <= nxt_t;
      best_det <= nxt_det;
    end
    if (hit_valid && last) begin    // fields read zero on a miss
      res_tag    <= tag;
      res_hit    <= nxt_hit;
      res_tri_id <= nxt_hit ? nxt_id : '0;
      res_t_num  <= nxt_hit ? nxt_t : '0;
      res_det    <= nxt_hit ? nxt_det : '0;
    end
  end

endmodule

/* verilog/isect_pipe.sv */
module isect_pipe import isect_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    tri_valid,
  input  vec_t    orig,
  input  vec_t    dir,
  input  vec_t    v0,
  input  vec_t    v1,
  input  vec_t    v2,
  input  tri_id_t tri_id,
  input  tag_t    tag,
  input  logic    last,
  output logic    hit_valid,
  output logic    hit,
  output prod_t   t_num,
  output prod_t   det,
  output tri_id_t out_tri_id,
  output tag_t    out_tag,
  output logic    out_last
);

  evec_t   e1_q   [3];    // stages 1 to 3
  evec_t   e2_q   [3];
  evec_t   tvec_q [3];
  evec_t   dir_q  [3];
  tri_id_t sb_id   [PIPE_LAT];
  tag_t    sb_tag  [PIPE_LAT];
  logic    sb_last [PIPE_LAT];
  logic    s1_valid, s4_valid;
  logic    pv_valid;
  cvec_t   pvec, qvec;
  prod_t   u_dot, v_dot;
  logic    neg;
  logic signed [PROD_W:0] su, sv, suv, st, adet;

  always_ff @(posedge clk) begin
    e1_q[0]   <= vec_sub(v1, v0);
    e2_q[0]   <= vec_sub(v2, v0);
    tvec_q[0] <= vec_sub(orig, v0);
    dir_q[0]  <= vec_sub(dir, '0);    // widen only
    for (int i = 1; i < 3; i++) begin
      e1_q[i]   <= e1_q[i-1];
      e2_q[i]   <= e2_q[i-1];
      tvec_q[i] <= tvec_q[i-1];
      dir_q[i]  <= dir_q[i-1];
    end
    sb_id[0]   <= tri_id;
    sb_tag[0]  <= tag;
    sb_last[0] <= last;
    for (int i = 1; i < PIPE_LAT; i++) begin
      sb_id[i]   <= sb_id[i-1];
      sb_tag[i]  <= sb_tag[i-1];
      sb_last[i] <= sb_last[i-1];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s4_valid  <= 1'b0;
      hit_valid <= 1'b0;
    end else begin
      s1_valid  <= tri_valid;
      s4_valid  <= pv_valid;
      hit_valid <= s4_valid;
    end
  end

  vec_cross u_pvec (.clk(clk), .rst(rst), .in_valid(s1_valid), .a(dir_q[0]), .b(e2_q[0]),
                    .out_valid(pv_valid), .y(pvec));
  vec_cross u_qvec (.clk(clk), .rst(rst), .in_valid(s1_valid), .a(tvec_q[0]), .b(e1_q[0]),
                    .out_valid(), .y(qvec));

  vec_dot u_det (.clk(clk), .rst(rst), .a(e1_q[2]),   .b(pvec), .y(det));
  vec_dot u_u   (.clk(clk), .rst(rst), .a(tvec_q[2]), .b(pvec), .y(u_dot));
  vec_dot u_v   (.clk(clk), .rst(rst), .a(dir_q[2]),  .b(qvec), .y(v_dot));
  vec_dot u_t   (.clk(clk), .rst(rst), .a(e2_q[2]),   .b(qvec), .y(t_num));

  // hit test on the stage 5 products scaled by the sign of det
  assign neg  = det[PROD_W-1];
  assign su   = neg ? -u_dot : u_dot;
  assign sv   = neg ? -v_dot : v_dot;
  assign suv  = neg ? -(u_dot + v_dot) : (u_dot + v_dot);
  assign st   = neg ? -t_num : t_num;
  assign adet = neg ? -det : det;
  assign hit  = (det != '0) && !su[PROD_W] && !sv[PROD_W] && (suv <= adet)
             && !st[PROD_W] && (st != '0);    // det == 0 also covers degenerate tris

  assign out_tri_id = sb_id[PIPE_LAT-1];
  assign out_tag    = sb_tag[PIPE_LAT-1];
  assign out_last   = sb_last[PIPE_LAT-1];

endmodule

/* verilog/isect_pkg.sv */
package isect_pkg;

  localparam int COORD_W  = 12;
  localparam int EDGE_W   = 13;
  localparam int CROSS_W  = 28;
  localparam int PROD_W   = 44;
  localparam int PIPE_LAT = 5;    // tri_valid to hit_valid in isect_pipe

  typedef logic signed [COORD_W-1:0] coord_t;
  typedef logic [3*COORD_W-1:0]      vec_t;    // {z, y, x}
  typedef logic signed [EDGE_W-1:0]  edge_t;
  typedef logic [3*EDGE_W-1:0]       evec_t;
  typedef logic signed [CROSS_W-1:0] cross_t;
  typedef logic [3*CROSS_W-1:0]      cvec_t;
  typedef logic signed [PROD_W-1:0]  prod_t;   // det, u, v, t_num
  typedef logic [7:0]                tri_id_t;
  typedef logic [5:0]                tag_t;

  typedef enum logic [1:0] {IDLE, SCAN, DRAIN} fetch_state_t;

  function automatic edge_t edge_of(evec_t v, int i);
    return edge_t'(v[EDGE_W*i +: EDGE_W]);
  endfunction

  function automatic cross_t cross_of(cvec_t v, int i);
    return cross_t'(v[CROSS_W*i +: CROSS_W]);
  endfunction

  // component-wise a - b, one bit wider so it never wraps
  function automatic evec_t vec_sub(vec_t a, vec_t b);
    evec_t r;
    for (int i = 0; i < 3; i++) begin
      r[EDGE_W*i +: EDGE_W] = edge_t'(coord_t'(a[COORD_W*i +: COORD_W]))
                            - edge_t'(coord_t'(b[COORD_W*i +: COORD_W]));
    end
    return r;
  endfunction

endpackage

/* verilog/ray_tri_unit.sv */
module ray_tri_unit import isect_pkg::*; #(
  parameter int TRI_COUNT   = 8,
  parameter int RAY_SLOTS   = 2,
  parameter int RES_CREDITS = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    ray_valid,
  input  vec_t    ray_orig,
  input  vec_t    ray_dir,
  input  tag_t    ray_tag,
  output logic    ray_credit,
  output logic    tri_rd_en,
  output tri_id_t tri_rd_addr,
  input  vec_t    tri_v0,
  input  vec_t    tri_v1,
  input  vec_t    tri_v2,
  output logic    res_valid,
  output tag_t    res_tag,
  output logic    res_hit,
  output tri_id_t res_tri_id,
  output prod_t   res_t_num,
  output prod_t   res_det,
  input  logic    res_credit
);

  logic    tri_valid, cur_last;    // fetch to pipe
  vec_t    cur_orig, cur_dir;
  tri_id_t cur_tri_id;
  tag_t    cur_tag;
  logic    hit_valid, hit, hit_last;    // pipe to select
  prod_t   t_num, det;
  tri_id_t hit_tri_id;
  tag_t    hit_tag;

  tri_fetch #(.TRI_COUNT(TRI_COUNT), .RAY_SLOTS(RAY_SLOTS), .RES_CREDITS(RES_CREDITS)) u_fetch (
    .clk(clk), .rst(rst), .ray_valid(ray_valid), .ray_orig(ray_orig), .ray_dir(ray_dir),
    .ray_tag(ray_tag), .res_credit(res_credit), .ray_credit(ray_credit),
    .tri_rd_en(tri_rd_en), .tri_rd_addr(tri_rd_addr), .tri_valid(tri_valid),
    .cur_orig(cur_orig), .cur_dir(cur_dir), .cur_tri_id(cur_tri_id), .cur_tag(cur_tag),
    .cur_last(cur_last)
  );

  isect_pipe u_pipe (
    .clk(clk), .rst(rst), .tri_valid(tri_valid), .orig(cur_orig), .dir(cur_dir),
    .v0(tri_v0), .v1(tri_v1), .v2(tri_v2), .tri_id(cur_tri_id), .tag(cur_tag),
    .last(cur_last), .hit_valid(hit_valid), .hit(hit), .t_num(t_num), .det(det),
    .out_tri_id(hit_tri_id), .out_tag(hit_tag), .out_last(hit_last)
  );

  hit_select u_select (
    .clk(clk), .rst(rst), .hit_valid(hit_valid), .hit(hit), .t_num(t_num), .det(det),
    .tri_id(hit_tri_id), .tag(hit_tag), .last(hit_last), .res_valid(res_valid),
    .res_tag(res_tag), .res_hit(res_hit), .res_tri_id(res_tri_id),
    .res_t_num(res_t_num), .res_det(res_det)
  );

endmodule

/* verilog/tri_fetch.sv */
module tri_fetch import isect_pkg::*; #(
  parameter int TRI_COUNT   = 8,
  parameter int RAY_SLOTS   = 2,
  parameter int RES_CREDITS = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    ray_valid,
  input  vec_t    ray_orig,
  input  vec_t    ray_dir,
  input  tag_t    ray_tag,
  input  logic    res_credit,
  output logic    ray_credit,
  output logic    tri_rd_en,
  output tri_id_t tri_rd_addr,
  output logic    tri_valid,
  output vec_t    cur_orig,
  output vec_t    cur_dir,
  output tri_id_t cur_tri_id,
  output tag_t    cur_tag,
  output logic    cur_last
);

  localparam int      PTR_W   = (RAY_SLOTS > 1) ? $clog2(RAY_SLOTS) : 1;
  localparam int      CNT_W   = $clog2(RAY_SLOTS + 1);
  localparam int      CRD_W   = $clog2(RES_CREDITS + 1);
  localparam tri_id_t LAST_ID = tri_id_t'(TRI_COUNT - 1);

  vec_t             q_orig [RAY_SLOTS];    // ray slot queue
  vec_t             q_dir  [RAY_SLOTS];
  tag_t             q_tag  [RAY_SLOTS];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] q_cnt;
  logic [CRD_W-1:0] res_cnt;               // free result slots downstream
  fetch_state_t     state;
  tri_id_t          addr;
  logic             start, pop;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(RAY_SLOTS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign start       = (state != SCAN) && (q_cnt != '0) && (res_cnt != '0);
  assign pop         = (state == SCAN) && (addr == LAST_ID);    // last read of the ray
  assign ray_credit  = pop;
  assign tri_rd_en   = (state == SCAN);
  assign tri_rd_addr = addr;

  always_ff @(posedge clk) begin
    if (ray_valid) begin
      q_orig[wr_ptr] <= ray_orig;
      q_dir[wr_ptr]  <= ray_dir;
      q_tag[wr_ptr]  <= ray_tag;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_cnt   <= '0;
      res_cnt <= CRD_W'(RES_CREDITS);
      state   <= IDLE;
      addr    <= '0;
    end else begin
      if (ray_valid)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      q_cnt   <= q_cnt + CNT_W'(ray_valid) - CNT_W'(pop);
      res_cnt <= res_cnt + CRD_W'(res_credit) - CRD_W'(start);    // slot held per ray
      case (state)
        IDLE, DRAIN: begin    // DRAIN is the cycle the queue head moves on
          addr  <= '0;
          state <= start ? SCAN : IDLE;
        end
        SCAN: begin
          if (pop)
            state <= DRAIN;
          else
            addr <= addr + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // sideband follows the read by one cycle, lined up with the vertex data
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      tri_valid <= 1'b0;
    else
      tri_valid <= tri_rd_en;
  end

  always_ff @(posedge clk) begin
    cur_orig   <= q_orig[rd_ptr];
    cur_dir    <= q_dir[rd_ptr];
    cur_tag    <= q_tag[rd_ptr];
    cur_tri_id <= addr;
    cur_last   <= pop;
  end

endmodule

/* verilog/vec_cross.sv */
module vec_cross import isect_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_valid,
  input  evec_t a,
  input  evec_t b,
  output logic  out_valid,
  output cvec_t y
);

  localparam int MUL_W = 2 * EDGE_W;

  logic signed [MUL_W-1:0] p [6];    // stage 1 partial products
  logic                    p_valid;

  always_ff @(posedge clk) begin
    p[0] <= edge_of(a, 1) * edge_of(b, 2);    // ay*bz
    p[1] <= edge_of(a, 2) * edge_of(b, 1);    // az*by
    p[2] <= edge_of(a, 2) * edge_of(b, 0);    // az*bx
    p[3] <= edge_of(a, 0) * edge_of(b, 2);    // ax*bz
    p[4] <= edge_of(a, 0) * edge_of(b, 1);    // ax*by
    p[5] <= edge_of(a, 1) * edge_of(b, 0);    // ay*bx
  end

  // stage 2, differences packed as {z, y, x}
  always_ff @(posedge clk) begin
    y <= {cross_t'(p[4]) - cross_t'(p[5]),
          cross_t'(p[2]) - cross_t'(p[3]),
          cross_t'(p[0]) - cross_t'(p[1])};
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      p_valid   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      p_valid   <= in_valid;
      out_valid <= p_valid;
    end
  end

endmodule

/* verilog/vec_dot.sv */
module vec_dot import isect_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  evec_t a,
  input  cvec_t b,
  output prod_t y
);

  localparam int MUL_W = EDGE_W + CROSS_W;

  logic signed [MUL_W-1:0] p [3];    // per-component products

  // valid lives in the parent's shift chain, so only the data is staged here
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 3; i++) begin
        p[i] <= '0;
      end
      y <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        p[i] <= edge_of(a, i) * cross_of(b, i);
      end
      y <= prod_t'(p[0]) + prod_t'(p[1]) + prod_t'(p[2]);    // stage 2 sum
    end
  end

endmodule
